/* src/cpuDefs_defs.svh */
// CPU sizing macros for data path, register file and data memory
`ifndef CPUDEFS_DEFS_SVH
`define CPUDEFS_DEFS_SVH

// ------------------------------------------------------------
// Data path
// ------------------------------------------------------------
`define DATA_WIDTH 32 // Data and instruction word

// ------------------------------------------------------------
// Register file
// ------------------------------------------------------------
`define REG_COUNT 32
`define REG_ADDR_WIDTH 5

// ------------------------------------------------------------
// Data memory
// ------------------------------------------------------------
`define DMEM_WORDS 64
`define DMEM_ADDR_WIDTH 6 // Word index width
`define DMEM_ADDR_LSB 2 // Byte offset bits below the word index

`endif

/* src/isaPkg.sv */
// Instruction set types for major opcodes, R-type function codes and field layout
`include "cpuDefs_defs.svh"

package isaPkg;

	// ------------------------------------------------------------
	// Major opcodes
	// ------------------------------------------------------------
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00, // Register-register ops, selected by funct
		OP_ADDIU = 6'h09, // Sign-extended immediate
		OP_ANDI  = 6'h0C, // Zero-extended immediate
		OP_ORI   = 6'h0D, // Zero-extended immediate
		OP_LUI   = 6'h0F, // Immediate into upper half
		OP_LW    = 6'h23,
		OP_SW    = 6'h2B
	} opcode_t;

	// ------------------------------------------------------------
	// R-type function codes
	// ------------------------------------------------------------
	typedef enum logic [5:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2A // Signed compare
	} funct_t;

	// Instruction word, MIPS field order
	// Low 16 bits double as the immediate
	typedef struct packed {
		opcode_t                    opcode; // 31:26
		logic [`REG_ADDR_WIDTH-1:0] rs;     // 25:21
		logic [`REG_ADDR_WIDTH-1:0] rt;     // 20:16
		logic [`REG_ADDR_WIDTH-1:0] rd;     // 15:11
		logic [4:0]                 shamt;  // Unused by kept ops
		funct_t                     funct;  // 5:0
	} instr_t;

endpackage

/* src/pipePkg.sv */
// Pipeline types for control word, decode bundle and register write record
`include "cpuDefs_defs.svh"

package pipePkg;

	// ALU operations
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,  // Signed less-than
		ALU_PASSB // Operand B straight through for LUI
	} aluOp_t;

	// Control word built in decode
	typedef struct packed {
		aluOp_t                     aluOp;
		logic                       useImm;   // B operand from immediate
		logic                       memRead;
		logic                       memWrite;
		logic                       regWrite; // Never set for register 0
		logic [`REG_ADDR_WIDTH-1:0] destReg;
	} ctrl_t;

	// ------------------------------------------------------------
	// Decode to execute
	// ------------------------------------------------------------
	typedef struct packed {
		ctrl_t                      ctrl;
		logic [`DATA_WIDTH-1:0]     regA;       // rs value
		logic [`DATA_WIDTH-1:0]     regB;       // rt value, also store data
		logic [`DATA_WIDTH-1:0]     operandImm; // Already extended
		logic [`REG_ADDR_WIDTH-1:0] rs;         // For forwarding compare
		logic [`REG_ADDR_WIDTH-1:0] rt;
	} decodeBundle_t;

	// Writeback record for register file port and trace
	typedef struct packed {
		logic                       valid;
		logic [`REG_ADDR_WIDTH-1:0] regAddr;
		logic [`DATA_WIDTH-1:0]     data;
	} regWrite_t;

endpackage

/* src/instrDecoder.sv */
// Instruction decoder mapping opcode and funct to a control word and extended operand
`include "cpuDefs_defs.svh"

module instrDecoder (
	input  isaPkg::instr_t         instr,
	input  logic                   instrValid,
	output pipePkg::ctrl_t         ctrl,
	output logic [`DATA_WIDTH-1:0] operandImm
);
	import isaPkg::*;
	import pipePkg::*;

	logic [15:0]            imm16;
	logic [`DATA_WIDTH-1:0] signExt;
	logic [`DATA_WIDTH-1:0] zeroExt;
	logic [`DATA_WIDTH-1:0] upperImm;
	ctrl_t                  rawCtrl;   // Before validity gating
	logic                   known;     // Recognized encoding
	logic                   writesReg; // Op has a register result

	// ------------------------------------------------------------
	// Immediate forms
	// ------------------------------------------------------------
	assign imm16    = instr[15:0];
	assign signExt  = {{(`DATA_WIDTH-16){imm16[15]}}, imm16};
	assign zeroExt  = {{(`DATA_WIDTH-16){1'b0}}, imm16};
	assign upperImm = {imm16, {(`DATA_WIDTH-16){1'b0}}}; // LUI

	// ------------------------------------------------------------
	// Control decode
	// ------------------------------------------------------------
	always_comb begin
		rawCtrl    = '0;
		known      = 1'b1;
		writesReg  = 1'b1;
		operandImm = signExt;
		rawCtrl.destReg = instr.rt; // I-type default
		case (instr.opcode)
			OP_RTYPE: begin
				rawCtrl.destReg = instr.rd;
				case (instr.funct)
					FN_ADDU: rawCtrl.aluOp = ALU_ADD;
					FN_SUBU: rawCtrl.aluOp = ALU_SUB;
					FN_AND:  rawCtrl.aluOp = ALU_AND;
					FN_OR:   rawCtrl.aluOp = ALU_OR;
					FN_XOR:  rawCtrl.aluOp = ALU_XOR;
					FN_SLT:  rawCtrl.aluOp = ALU_SLT;
					default: known = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				rawCtrl.aluOp  = ALU_ADD;
				rawCtrl.useImm = 1'b1;
			end
			OP_ANDI: begin
				rawCtrl.aluOp  = ALU_AND;
				rawCtrl.useImm = 1'b1;
				operandImm     = zeroExt;
			end
			OP_ORI: begin
				rawCtrl.aluOp  = ALU_OR;
				rawCtrl.useImm = 1'b1;
				operandImm     = zeroExt;
			end
			OP_LUI: begin
				rawCtrl.aluOp  = ALU_PASSB; // Shift already done here
				rawCtrl.useImm = 1'b1;
				operandImm     = upperImm;
			end
			OP_LW: begin
				rawCtrl.aluOp   = ALU_ADD; // Base plus offset
				rawCtrl.useImm  = 1'b1;
				rawCtrl.memRead = 1'b1;
			end
			OP_SW: begin
				rawCtrl.aluOp    = ALU_ADD;
				rawCtrl.useImm   = 1'b1;
				rawCtrl.memWrite = 1'b1;
				writesReg        = 1'b0; // rt is the data source
			end
			default: known = 1'b0;
		endcase

		// Writes to r0 are dropped here so no later stage sees them
		rawCtrl.regWrite = writesReg && (rawCtrl.destReg != '0);

		// Bubble or unknown encoding gives all enables low
		ctrl = (instrValid && known) ? rawCtrl : '0;
	end

endmodule

/* src/regFile.sv */
// Register file with two read ports, one write port, zero register and write-through
`include "cpuDefs_defs.svh"

module regFile (
	input  logic                       clock,
	input  logic                       reset,
	input  logic [`REG_ADDR_WIDTH-1:0] addrA,
	input  logic [`REG_ADDR_WIDTH-1:0] addrB,
	output logic [`DATA_WIDTH-1:0]     readA,
	output logic [`DATA_WIDTH-1:0]     readB,
	input  pipePkg::regWrite_t         write
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	// Write port, r0 never stored
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (write.valid && write.regAddr != '0) begin
			regs[write.regAddr] <= write.data;
		end
	end

	// One read port, bypassing a same-edge write
	function automatic logic [`DATA_WIDTH-1:0] readPort(
		input logic [`REG_ADDR_WIDTH-1:0] addr
	);
		logic [`DATA_WIDTH-1:0] value;
		if (addr == '0)
			value = '0; // Hardwired zero
		else if (write.valid && write.regAddr == addr)
			value = write.data; // Write-through
		else
			value = regs[addr];
		return value;
	endfunction

	always_comb readA = readPort(addrA);
	always_comb readB = readPort(addrB);

	// Decode drops r0 writes, so none may reach the port
	noZeroWrite: assert property (@(posedge clock) disable iff (reset)
		write.valid |-> write.regAddr != '0)
		else $error("regFile: valid write aimed at register 0");

endmodule

/* src/dataMemory.sv */
// Word-addressed data memory with synchronous write and combinational read
`include "cpuDefs_defs.svh"

module dataMemory (
	input  logic                        clock,
	input  logic                        reset,
	input  logic [`DMEM_ADDR_WIDTH-1:0] addr,        // Word index
	input  logic [`DATA_WIDTH-1:0]      writeData,
	input  logic                        readEnable,
	input  logic                        writeEnable,
	output logic [`DATA_WIDTH-1:0]      readData
);

	logic [`DATA_WIDTH-1:0] mem [`DMEM_WORDS];

	// Store at the edge
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `DMEM_WORDS; i++) begin
				mem[i] <= '0; // All words read zero after reset
			end
		end else if (writeEnable) begin
			mem[addr] <= writeData;
		end
	end

	// Same-cycle read, zero when idle
	assign readData = readEnable ? mem[addr] : '0;

endmodule

/* src/executeStage.sv */
// Execute/memory and writeback stages with forwarding, ALU, data memory and result select
`include "cpuDefs_defs.svh"

module executeStage (
	input  logic                   clock,
	input  logic                   reset,
	input  pipePkg::decodeBundle_t bundle,
	output pipePkg::regWrite_t     wbOut
);
	import pipePkg::*;

	decodeBundle_t          exBundle;  // Execute-stage copy of decode output
	logic [`DATA_WIDTH-1:0] fwdA;      // rs after forwarding
	logic [`DATA_WIDTH-1:0] fwdB;      // rt after forwarding
	logic [`DATA_WIDTH-1:0] aluB;
	logic [`DATA_WIDTH-1:0] aluResult;
	logic [`DATA_WIDTH-1:0] loadData;
	logic                   memAccess;

	// ------------------------------------------------------------
	// Decode to execute register
	// ------------------------------------------------------------
	always_ff @(posedge clock) begin
		exBundle <= bundle;
		if (reset)
			exBundle.ctrl <= '0; // Bubble, payload left as is
	end

	// Writeback result into both operands
	// Older values came through the register file write-through
	assign fwdA = (wbOut.valid && wbOut.regAddr == exBundle.rs) ? wbOut.data : exBundle.regA;
	assign fwdB = (wbOut.valid && wbOut.regAddr == exBundle.rt) ? wbOut.data : exBundle.regB;
	assign aluB = exBundle.ctrl.useImm ? exBundle.operandImm : fwdB;

	// ------------------------------------------------------------
	// ALU
	// ------------------------------------------------------------
	always_comb begin
		case (exBundle.ctrl.aluOp)
			ALU_ADD:   aluResult = fwdA + aluB;
			ALU_SUB:   aluResult = fwdA - aluB;
			ALU_AND:   aluResult = fwdA & aluB;
			ALU_OR:    aluResult = fwdA | aluB;
			ALU_XOR:   aluResult = fwdA ^ aluB;
			ALU_SLT:   aluResult = {{(`DATA_WIDTH-1){1'b0}}, $signed(fwdA) < $signed(aluB)};
			ALU_PASSB: aluResult = aluB;
			default:   aluResult = '0;
		endcase
	end

	// ------------------------------------------------------------
	// Memory access at the ALU result
	// ------------------------------------------------------------
	assign memAccess = exBundle.ctrl.memRead || exBundle.ctrl.memWrite;

	dataMemory dataMemory_i (
		.clock       (clock),
		.reset       (reset),
		.addr        (aluResult[`DMEM_ADDR_LSB +: `DMEM_ADDR_WIDTH]), // Upper bits ignored
		.writeData   (fwdB),                   // Store data is forwarded too
		.readEnable  (exBundle.ctrl.memRead),
		.writeEnable (exBundle.ctrl.memWrite),
		.readData    (loadData)
	);

	// Writeback register, load data or ALU result
	always_ff @(posedge clock) begin
		wbOut.regAddr <= exBundle.ctrl.destReg;
		wbOut.data    <= exBundle.ctrl.memRead ? loadData : aluResult;
		if (reset)
			wbOut.valid <= 1'b0;
		else
			wbOut.valid <= exBundle.ctrl.regWrite;
	end

	// Word accesses only
	wordAligned: assert property (@(posedge clock) disable iff (reset)
		memAccess |-> aluResult[`DMEM_ADDR_LSB-1:0] == '0)
		else $error("executeStage: unaligned access at %h", aluResult);

endmodule

/* src/pipelineCore.sv */
// Pipeline top with fetch register, decode and execute stages and the register file
`include "cpuDefs_defs.svh"

module pipelineCore (
	input  logic               clock,
	input  logic               reset,
	input  isaPkg::instr_t     instrIn,
	input  logic               instrValid,
	output pipePkg::regWrite_t writeTrace
);
	import isaPkg::*;
	import pipePkg::*;

	instr_t                 fetchInstr; // Decode-stage instruction
	logic                   fetchValid;
	ctrl_t                  decCtrl;
	logic [`DATA_WIDTH-1:0] decImm;
	logic [`DATA_WIDTH-1:0] readA;
	logic [`DATA_WIDTH-1:0] readB;
	decodeBundle_t          decBundle;
	regWrite_t              wbRecord;   // Register write and trace

	// ------------------------------------------------------------
	// Fetch register
	// ------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset)
			fetchValid <= 1'b0;
		else
			fetchValid <= instrValid; // Accepted every valid edge
	end

	always_ff @(posedge clock) begin
		if (instrValid)
			fetchInstr <= instrIn;
	end

	// Decode, side by side with register read
	instrDecoder instrDecoder_i (
		.instr      (fetchInstr),
		.instrValid (fetchValid),
		.ctrl       (decCtrl),
		.operandImm (decImm)
	);

	regFile regFile_i (
		.clock (clock),
		.reset (reset),
		.addrA (fetchInstr.rs),
		.addrB (fetchInstr.rt),
		.readA (readA),
		.readB (readB),
		.write (wbRecord)
	);

	// Bundle for execute
	always_comb begin
		decBundle.ctrl       = decCtrl;
		decBundle.regA       = readA;
		decBundle.regB       = readB;
		decBundle.operandImm = decImm;
		decBundle.rs         = fetchInstr.rs;
		decBundle.rt         = fetchInstr.rt;
	end

	executeStage executeStage_i (
		.clock  (clock),
		.reset  (reset),
		.bundle (decBundle),
		.wbOut  (wbRecord)
	);

	assign writeTrace = wbRecord; // Two edges after acceptance

endmodule

/* bench/tbClock.sv */
// Testbench clock and reset source for the pipeline, 10 ns period
module tbClock (
	output logic clock,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	// Free-running clock, 10 ns period
	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Held for 4 rising edges, released just after the last one
	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clock);
		#1 reset = 1'b0;
	end

endmodule

/* bench/tbTop.sv */
// Testbench for the pipeline with random instructions, reference model and trace checker
`include "cpuDefs_defs.svh"

module tbTop;
	timeunit 1ns;
	timeprecision 100ps;
	import isaPkg::*;
	import pipePkg::*;

	localparam int NUM_RANDOM = 2000; // Accepted random instructions
	localparam int TIMEOUT_NS = (NUM_RANDOM * 2 + 300) * 10;

	// One expected register write and its acceptance edge
	typedef struct packed {
		logic [`REG_ADDR_WIDTH-1:0] regAddr;
		logic [`DATA_WIDTH-1:0]     data;
		int                         acceptEdge;
	} expectEntry_t;

	logic                   clock;
	logic                   reset;
	instr_t                 instrIn;
	logic                   instrValid;
	regWrite_t              writeTrace;
	integer                 seed;
	int                     edgeCount;   // Edges seen by the driver
	logic [`DATA_WIDTH-1:0] modelRegs [`REG_COUNT];
	logic [`DATA_WIDTH-1:0] modelMem [`DMEM_WORDS];
	expectEntry_t           expectQ [$]; // Writes in program order

	tbClock tbClock_i (.clock(clock), .reset(reset));

	pipelineCore pipelineCore_i (
		.clock      (clock),
		.reset      (reset),
		.instrIn    (instrIn),
		.instrValid (instrValid),
		.writeTrace (writeTrace)
	);

	// ------------------------------------------------------------
	// Failure reporting
	// ------------------------------------------------------------
	task automatic abortRun();
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic checkEqual(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERR time=%0t %s actual=%h expected=%h", $time, name, actual, expected);
			abortRun();
		end
	endtask

	// ------------------------------------------------------------
	// Instruction builders
	// ------------------------------------------------------------
	function automatic instr_t buildRType(input funct_t fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		instr_t word;
		word        = '0;
		word.opcode = OP_RTYPE;
		word.rs     = rs;
		word.rt     = rt;
		word.rd     = rd;
		word.funct  = fn;
		return word;
	endfunction

	// Assembler operand order with rt first
	function automatic instr_t buildIType(input opcode_t op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return instr_t'({op, rs, rt, imm});
	endfunction

	// Registers 0 to 7 only so dependencies are frequent
	task automatic makeRandomInstr(output instr_t instr);
		int          pick;
		logic [4:0]  rd;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
		logic [15:0] offset;
		pick   = $unsigned($random(seed)) % 12;
		rd     = 5'($unsigned($random(seed)) % 8);
		rs     = 5'($unsigned($random(seed)) % 8);
		rt     = 5'($unsigned($random(seed)) % 8);
		imm    = 16'($random(seed));
		offset = 16'(($unsigned($random(seed)) % 64) * 4); // Word offsets below 256
		case (pick)
			0:       instr = buildRType(FN_ADDU, rd, rs, rt);
			1:       instr = buildRType(FN_SUBU, rd, rs, rt);
			2:       instr = buildRType(FN_AND, rd, rs, rt);
			3:       instr = buildRType(FN_OR, rd, rs, rt);
			4:       instr = buildRType(FN_XOR, rd, rs, rt);
			5:       instr = buildRType(FN_SLT, rd, rs, rt);
			6:       instr = buildIType(OP_ADDIU, rt, rs, imm);
			7:       instr = buildIType(OP_ANDI, rt, rs, imm);
			8:       instr = buildIType(OP_ORI, rt, rs, imm);
			9:       instr = buildIType(OP_LUI, rt, rs, imm);
			10:      instr = buildIType(OP_LW, rt, 5'd0, offset); // Base r0
			default: instr = buildIType(OP_SW, rt, 5'd0, offset);
		endcase
	endtask

	// ------------------------------------------------------------
	// Reference model executing in program order
	// ------------------------------------------------------------
	task automatic modelExecute(input instr_t instr);
		logic [31:0]  a;
		logic [31:0]  b;
		logic [31:0]  immS;
		logic [31:0]  immZ;
		logic [31:0]  result;
		logic [31:0]  addr;
		logic [4:0]   dest;
		logic         writes;
		expectEntry_t entry;
		a      = modelRegs[instr.rs];
		b      = modelRegs[instr.rt];
		immS   = {{16{instr[15]}}, instr[15:0]};
		immZ   = {16'h0000, instr[15:0]};
		result = '0;
		addr   = '0;
		dest   = instr.rt;
		writes = 1'b1;
		case (instr.opcode)
			OP_RTYPE: begin
				dest = instr.rd;
				case (instr.funct)
					FN_ADDU: result = a + b;
					FN_SUBU: result = a - b;
					FN_AND:  result = a & b;
					FN_OR:   result = a | b;
					FN_XOR:  result = a ^ b;
					FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: writes = 1'b0;
				endcase
			end
			OP_ADDIU: result = a + immS;
			OP_ANDI:  result = a & immZ;
			OP_ORI:   result = a | immZ;
			OP_LUI:   result = {instr[15:0], 16'h0000};
			OP_LW: begin
				addr   = a + immS;
				result = modelMem[addr[7:2]];
			end
			OP_SW: begin
				addr                = a + immS;
				modelMem[addr[7:2]] = b;
				writes              = 1'b0;
			end
			default: writes = 1'b0;
		endcase
		if (writes && dest != 5'd0) begin // r0 stays zero and gives no trace
			modelRegs[dest]  = result;
			entry.regAddr    = dest;
			entry.data       = result;
			entry.acceptEdge = edgeCount;
			expectQ.push_back(entry);
		end
	endtask

	// Drive one slot and count its accepting edge before settling 1 ns later
	task automatic applySlot(input logic valid, input instr_t instr);
		instrIn    = instr;
		instrValid = valid;
		@(posedge clock);
		edgeCount++;
		if (valid)
			modelExecute(instr);
		#1;
	endtask

	// ------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------
	initial begin : stimulus
		instr_t instr;
		int     accepted;
		seed       = 19605;
		instrIn    = '0;
		instrValid = 1'b0;
		edgeCount  = 0;
		accepted   = 0;
		for (int i = 0; i < `REG_COUNT; i++)
			modelRegs[i] = '0;
		for (int i = 0; i < `DMEM_WORDS; i++)
			modelMem[i] = '0;
		@(negedge reset);
		repeat (3) applySlot(1'b0, '0); // Idle after reset with no trace expected

		// Directed prologue
		applySlot(1'b1, buildRType(FN_ADDU, 5'd1, 5'd2, 5'd3));      // Zero after reset
		applySlot(1'b1, buildIType(OP_LUI, 5'd1, 5'd0, 16'h8000));
		applySlot(1'b1, buildIType(OP_ORI, 5'd1, 5'd1, 16'hF234));   // Distance 1
		applySlot(1'b1, buildIType(OP_ADDIU, 5'd2, 5'd0, 16'hFFFF)); // Minus one
		applySlot(1'b1, buildRType(FN_SLT, 5'd3, 5'd1, 5'd2));       // Distances 1 and 2
		applySlot(1'b1, buildIType(OP_ANDI, 5'd4, 5'd2, 16'h80F0));
		applySlot(1'b1, buildRType(FN_SUBU, 5'd5, 5'd4, 5'd2));      // Distances 1 and 3
		applySlot(1'b1, buildIType(OP_SW, 5'd1, 5'd0, 16'h0008));
		applySlot(1'b1, buildIType(OP_LW, 5'd6, 5'd0, 16'h0008));    // Right after store
		applySlot(1'b1, buildRType(FN_XOR, 5'd7, 5'd6, 5'd5));       // Load used at once
		applySlot(1'b1, buildRType(FN_ADDU, 5'd0, 5'd1, 5'd2));      // r0 write gives no trace
		applySlot(1'b1, buildRType(FN_OR, 5'd3, 5'd0, 5'd0));        // r0 still zero

		// Random stream with about one slot in five left invalid
		while (accepted < NUM_RANDOM) begin
			makeRandomInstr(instr);
			if ($unsigned($random(seed)) % 5 == 0) begin
				applySlot(1'b0, instr);
			end else begin
				applySlot(1'b1, instr);
				accepted++;
			end
		end

		repeat (4) applySlot(1'b0, '0); // Drain covers the 2-edge latency
		if (expectQ.size() != 0) begin
			$display("Drain ended with %0d expected writes never traced", expectQ.size());
			abortRun();
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// Trace checker sampling mid-cycle
	// ------------------------------------------------------------
	always @(negedge clock) begin
		expectEntry_t exp;
		if (!reset && writeTrace.valid === 1'b1) begin
			if (expectQ.size() == 0) begin
				$display("Unexpected register write on writeTrace at time %0t", $time);
				abortRun();
			end else begin
				exp = expectQ.pop_front();
				checkEqual("writeTrace.regAddr", 32'(writeTrace.regAddr), 32'(exp.regAddr));
				checkEqual("writeTrace.data", writeTrace.data, exp.data);
				checkEqual("writeTrace latency", 32'(edgeCount - exp.acceptEdge), 32'd2);
			end
		end else if (!reset && writeTrace.valid !== 1'b0) begin
			$display("writeTrace.valid is unknown at time %0t", $time);
			abortRun();
		end
	end

	// Watchdog sized from the instruction count
	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired after %0d ns before the run finished", TIMEOUT_NS);
		abortRun();
	end

endmodule

/* tb.f */
+incdir+src
src/isaPkg.sv
src/pipePkg.sv
src/instrDecoder.sv
src/regFile.sv
src/dataMemory.sv
src/executeStage.sv
src/pipelineCore.sv
bench/tbClock.sv
bench/tbTop.sv

/* Makefile */
# Verilator build and run for the pipeline testbench

VERILATOR       ?= verilator
TOP             ?= tbTop
FILELIST        ?= tb.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
PASS_TEXT       ?= Regression passed
VERILATOR_FLAGS ?= --binary --timing --assert -j 0 -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard src/*.sv src/*.svh bench/*.sv)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
